// File: sim.f
design/eth_pkg.sv
design/packet_ring.sv
design/gmii_tx_framer.sv
design/gmii_rx_deframer.sv
design/host_cmd_decoder.sv
design/eth_mac_top.sv
tb/eth_mac_properties.sv
tb/tb_eth_mac.sv

// File: Makefile
TOP := tb_eth_mac

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: tb/tb_eth_mac.sv
`timescale 1ns/1ps

module tb_eth_mac;
	import eth_pkg::*;

	localparam int NUM_SLOTS   = 4;
	localparam int SLOT_BYTES  = 64;
	localparam int CLK_PERIOD  = 8;
	localparam int MAX_LEN     = 40;
	localparam int NUM_FRAMES  = 5 + NUM_SLOTS; // two sent, three bad, ring fill
	localparam int WIRE_CYCLES = NUM_FRAMES * (MAX_LEN + 12 + IFG_CYCLES + 8);
	localparam int HOST_CYCLES = NUM_FRAMES * 2 * (MAX_LEN + 8) * 2;
	localparam int WATCHDOG_NS = 2 * (WIRE_CYCLES + HOST_CYCLES + 200) * CLK_PERIOD;

	logic        clock;
	logic        reset;
	logic        start;
	host_req_s   req;
	host_rsp_s   rsp;
	gmii_tx_s    gmii_tx;
	gmii_rx_s    gmii_rx;
	gmii_rx_s    inj_rx;
	logic        loopback;
	int          tx_frames = 0;
	logic [31:0] lfsr_state = 32'hce4e;
	byte_t       pay [SLOT_BYTES];
	byte_t       exp_tx_bytes [$];
	int          exp_tx_len [$];
	byte_t       exp_rx_bytes [$];
	int          exp_rx_len [$];

	eth_mac_top #(.NUM_SLOTS(NUM_SLOTS), .SLOT_BYTES(SLOT_BYTES)) UUT (
		.clock    (clock),
		.reset    (reset),
		.start_i  (start),
		.req_i    (req),
		.rsp_o    (rsp),
		.gmii_tx_o(gmii_tx),
		.gmii_rx_i(gmii_rx)
	);

	always_comb begin
		if (loopback) begin
			gmii_rx.rxd   = gmii_tx.txd;
			gmii_rx.rx_dv = gmii_tx.tx_en;
			gmii_rx.rx_er = 1'b0;
		end else begin
			gmii_rx = inj_rx;
		end
	end

	initial begin
		clock = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clock = ~clock;
		end
	end

	// ------------------------------
	// reference model

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[14:0], fb};
		end
		return v;
	endfunction

	// bit serial crc-32, lsb first, fcs is the complement
	function automatic logic [31:0] ref_fcs(input byte_t data [SLOT_BYTES], input int len);
		logic [31:0] crc;
		logic        fb;
		crc = 32'hFFFFFFFF;
		for (int i = 0; i < len; i++) begin
			for (int b = 0; b < 8; b++) begin
				fb  = crc[0] ^ data[i][b];
				crc = crc >> 1;
				if (fb) begin
					crc = crc ^ 32'hEDB88320;
				end
			end
		end
		return ~crc;
	endfunction

	task automatic fail_stop();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			fail_stop();
		end
	endtask

	task automatic make_payload(input int len);
		for (int i = 0; i < len; i++) begin
			pay[i] = 8'(rand_bits(8));
		end
	endtask

	task automatic queue_tx_frame(input int len);
		logic [31:0] fcs;
		fcs = ref_fcs(pay, len);
		for (int i = 0; i < PREAMBLE_LEN; i++) begin
			exp_tx_bytes.push_back(PREAMBLE_BYTE);
		end
		exp_tx_bytes.push_back(SFD_BYTE);
		for (int i = 0; i < len; i++) begin
			exp_tx_bytes.push_back(pay[i]);
		end
		for (int i = 0; i < FCS_BYTES; i++) begin
			exp_tx_bytes.push_back(fcs[8*i +: 8]); // low byte first
		end
		exp_tx_len.push_back(PREAMBLE_LEN + 1 + len + FCS_BYTES);
	endtask

	task automatic note_rx_packet(input int len);
		exp_rx_len.push_back(len);
		for (int i = 0; i < len; i++) begin
			exp_rx_bytes.push_back(pay[i]);
		end
	endtask

	// ------------------------------
	// host side

	task automatic send_cmd(input host_op_e op, input int addr, input byte_t wdata,
			output logic [15:0] result);
		int waited;
		@(posedge clock);
		#1;
		req.op    = op;
		req.addr  = 16'(addr);
		req.wdata = wdata;
		start     = 1'b1;
		@(posedge clock);
		#1;
		start  = 1'b0;
		waited = 0;
		while (!rsp.done) begin
			if (waited == 4) begin
				$display("host command %s never returned done", op.name());
				fail_stop();
			end
			@(posedge clock);
			#1;
			waited++;
		end
		result = rsp.result;
	endtask

	task automatic check_cmd(input host_op_e op, input int addr, input byte_t wdata,
			input logic [15:0] exp);
		logic [15:0] res;
		send_cmd(op, addr, wdata, res);
		compare_val($sformatf("rsp_o.result (%s addr %0d)", op.name(), addr),
			32'(res), 32'(exp));
	endtask

	task automatic write_packet(input int len);
		for (int i = 0; i < len; i++) begin
			check_cmd(OP_WRITE, i, pay[i], 16'd0);
		end
	endtask

	task automatic read_back();
		int          len;
		logic [15:0] exp_val;
		len = exp_rx_len.pop_front();
		check_cmd(OP_READ_LEN, 0, 8'h00, 16'(len));
		for (int i = 0; i < len; i++) begin
			exp_val = {8'h00, exp_rx_bytes.pop_front()};
			check_cmd(OP_READ, i, 8'h00, exp_val);
		end
		check_cmd(OP_READ, len, 8'h00, 16'd0); // past the end
		check_cmd(OP_READ_NEXT, 0, 8'h00, 16'd0);
	endtask

	// ------------------------------
	// gmii side

	task automatic drive_rx(input byte_t d, input logic dv, input logic er);
		@(posedge clock);
		#1;
		inj_rx.rxd   = d;
		inj_rx.rx_dv = dv;
		inj_rx.rx_er = er;
	endtask

	task automatic inject_frame(input int len, input int pre_len, input int flip_at,
			input int err_at);
		logic [31:0] fcs;
		byte_t       wire_b [SLOT_BYTES + FCS_BYTES];
		fcs = ref_fcs(pay, len);
		for (int i = 0; i < len; i++) begin
			wire_b[i] = pay[i];
		end
		for (int i = 0; i < FCS_BYTES; i++) begin
			wire_b[len + i] = fcs[8*i +: 8];
		end
		if (flip_at >= 0) begin
			wire_b[flip_at] = wire_b[flip_at] ^ 8'h10; // corrupt after fcs
		end
		for (int i = 0; i < pre_len; i++) begin
			drive_rx(PREAMBLE_BYTE, 1'b1, 1'b0);
		end
		drive_rx(SFD_BYTE, 1'b1, 1'b0);
		for (int i = 0; i < len + FCS_BYTES; i++) begin
			drive_rx(wire_b[i], 1'b1, i == err_at);
		end
		for (int i = 0; i < 4; i++) begin
			drive_rx(8'h00, 1'b0, 1'b0);
		end
	endtask

	task automatic wait_tx_frames(input int n, input int max_cycles);
		int cycles;
		cycles = 0;
		while (tx_frames < n) begin
			if (cycles == max_cycles) begin
				$display("expected frames did not leave the transmit port within %0d cycles",
					max_cycles);
				fail_stop();
			end
			@(posedge clock);
			cycles++;
		end
	endtask

	initial begin : tx_monitor
		int    count;
		logic  in_frame;
		byte_t exp_b;
		count    = 0;
		in_frame = 1'b0;
		forever begin
			@(negedge clock);
			if (gmii_tx.tx_en) begin
				if (exp_tx_bytes.size() == 0) begin
					$display("transmit port sent a byte that no frame accounts for");
					fail_stop();
				end
				exp_b = exp_tx_bytes.pop_front();
				compare_val($sformatf("gmii_tx_o.txd[%0d]", count),
					32'(gmii_tx.txd), 32'(exp_b));
				count++;
				in_frame = 1'b1;
			end else if (in_frame) begin
				compare_val("gmii_tx_o.tx_en cycles", 32'(count), 32'(exp_tx_len.pop_front()));
				count    = 0;
				in_frame = 1'b0;
				tx_frames++;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		fail_stop();
	end

	// ------------------------------
	// test sequence

	initial begin : main_seq
		int len;
		start    = 1'b0;
		req      = '0;
		inj_rx   = '0;
		loopback = 1'b1;
		reset    = 1'b1;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		compare_val("rsp_o.done", 32'(rsp.done), 32'd0);
		compare_val("gmii_tx_o.tx_en", 32'(gmii_tx.tx_en), 32'd0);
		check_cmd(OP_READ_LEN, 0, 8'h00, 16'd0);
		check_cmd(OP_READ_NEXT, 0, 8'h00, 16'd1);
		check_cmd(OP_WRITE_LEN, 0, 8'h00, 16'd0);

		check_cmd(OP_WRITE_NEXT, 0, 8'h00, 16'd1); // empty packet refused
		len = 1 + int'(rand_bits(6)) % MAX_LEN;
		make_payload(len);
		write_packet(len);
		check_cmd(OP_WRITE_LEN, 0, 8'h00, 16'(len));
		check_cmd(OP_WRITE, SLOT_BYTES, 8'hA5, 16'd1);
		check_cmd(OP_WRITE_LEN, 0, 8'h00, 16'(len));

		queue_tx_frame(len);
		note_rx_packet(len); // loops back into the receiver
		check_cmd(OP_WRITE_NEXT, 0, 8'h00, 16'd0);

		// short second packet, committed before the first gap ends
		len = 1 + int'(rand_bits(3));
		make_payload(len);
		write_packet(len);
		queue_tx_frame(len);
		note_rx_packet(len);
		check_cmd(OP_WRITE_NEXT, 0, 8'h00, 16'd0);
		wait_tx_frames(2, 2 * (MAX_LEN + 12 + IFG_CYCLES + 8));
		repeat (2) @(posedge clock);

		read_back();
		read_back();
		check_cmd(OP_READ_NEXT, 0, 8'h00, 16'd1);

		@(posedge clock);
		#1;
		loopback = 1'b0;
		len = 1 + int'(rand_bits(6)) % MAX_LEN;
		make_payload(len);
		inject_frame(len, PREAMBLE_LEN, len / 2, -1);
		check_cmd(OP_READ_LEN, 0, 8'h00, 16'd0);
		inject_frame(len, PREAMBLE_LEN - 1, -1, -1);
		check_cmd(OP_READ_LEN, 0, 8'h00, 16'd0);
		inject_frame(len, PREAMBLE_LEN, -1, len / 2);
		check_cmd(OP_READ_LEN, 0, 8'h00, 16'd0);
		check_cmd(OP_READ_NEXT, 0, 8'h00, 16'd1);

		for (int k = 0; k < NUM_SLOTS; k++) begin
			len = 1 + int'(rand_bits(6)) % MAX_LEN;
			make_payload(len);
			if (k < NUM_SLOTS - 1) begin
				note_rx_packet(len);
			end
			inject_frame(len, PREAMBLE_LEN, -1, -1);
		end
		for (int k = 0; k < NUM_SLOTS - 1; k++) begin
			read_back();
		end
		check_cmd(OP_READ_NEXT, 0, 8'h00, 16'd1);

		compare_val("transmitted frame count", 32'(tx_frames), 32'd2);
		compare_val("unsent expected bytes", 32'(exp_tx_bytes.size()), 32'd0);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: tb/eth_mac_properties.sv
`timescale 1ns/1ps

module eth_mac_properties (
	input logic clock,
	input logic reset,
	input logic start_i,
	input logic done_i,
	input logic tx_en_i
);
	import eth_pkg::*;

	logic [7:0] idle_run; // low cycles since the last frame, saturating

	always_ff @(posedge clock) begin
		if (reset) begin
			idle_run <= 8'(IFG_CYCLES);
		end else if (tx_en_i) begin
			idle_run <= '0;
		end else if (idle_run != 8'hFF) begin
			idle_run <= idle_run + 8'd1;
		end
	end

	done_after_start: assert property (@(posedge clock) disable iff (reset)
		start_i |=> done_i)
		else $error("done did not follow start by one cycle");

	done_needs_start: assert property (@(posedge clock) disable iff (reset)
		done_i |-> $past(start_i))
		else $error("done without a start one cycle before");

	done_one_cycle: assert property (@(posedge clock) disable iff (reset)
		done_i |=> !done_i)
		else $error("done held for two cycles");

	gap_respected: assert property (@(posedge clock) disable iff (reset)
		$rose(tx_en_i) |-> (idle_run >= 8'(IFG_CYCLES)))
		else $error("tx_en rose before the inter-frame gap ended");

endmodule

bind host_cmd_decoder eth_mac_properties u_cmd_props (
	.clock  (clock),
	.reset  (reset),
	.start_i(start_i),
	.done_i (rsp_o.done),
	.tx_en_i(1'b0)
);

bind gmii_tx_framer eth_mac_properties u_tx_props (
	.clock  (clock),
	.reset  (reset),
	.start_i(1'b0),
	.done_i (1'b0),
	.tx_en_i(gmii_o.tx_en)
);

// File: design/eth_mac_top.sv
`timescale 1ns/1ps

module eth_mac_top #(
	parameter int NUM_SLOTS  = 4,
	parameter int SLOT_BYTES = 64
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               start_i,
	input  eth_pkg::host_req_s req_i,
	output eth_pkg::host_rsp_s rsp_o,
	output eth_pkg::gmii_tx_s  gmii_tx_o,
	input  eth_pkg::gmii_rx_s  gmii_rx_i
);
	import eth_pkg::*;

	ring_wr_s   tx_wr;
	ring_rd_s   tx_rd;
	ring_stat_s tx_stat;
	ring_wr_s   rx_wr;
	ring_rd_s   rx_rd;
	ring_stat_s rx_stat;

	host_cmd_decoder #(.SLOT_BYTES(SLOT_BYTES)) u_cmd_decoder (
		.clock    (clock),
		.reset    (reset),
		.start_i  (start_i),
		.req_i    (req_i),
		.rsp_o    (rsp_o),
		.tx_wr_o  (tx_wr),
		.tx_stat_i(tx_stat),
		.rx_rd_o  (rx_rd),
		.rx_stat_i(rx_stat)
	);

	packet_ring #(.NUM_SLOTS(NUM_SLOTS), .SLOT_BYTES(SLOT_BYTES), .TRIM_BYTES(0)) tx_ring (
		.clock (clock),
		.reset (reset),
		.wr_i  (tx_wr),
		.rd_i  (tx_rd),
		.stat_o(tx_stat)
	);

	// receive slots drop the fcs on commit
	packet_ring #(.NUM_SLOTS(NUM_SLOTS), .SLOT_BYTES(SLOT_BYTES), .TRIM_BYTES(FCS_BYTES)) rx_ring (
		.clock (clock),
		.reset (reset),
		.wr_i  (rx_wr),
		.rd_i  (rx_rd),
		.stat_o(rx_stat)
	);

	gmii_tx_framer u_tx_framer (
		.clock (clock),
		.reset (reset),
		.rd_o  (tx_rd),
		.stat_i(tx_stat),
		.gmii_o(gmii_tx_o)
	);

	gmii_rx_deframer #(.SLOT_BYTES(SLOT_BYTES)) u_rx_deframer (
		.clock (clock),
		.reset (reset),
		.gmii_i(gmii_rx_i),
		.wr_o  (rx_wr),
		.stat_i(rx_stat)
	);

endmodule

// File: design/host_cmd_decoder.sv
`timescale 1ns/1ps

module host_cmd_decoder #(
	parameter int SLOT_BYTES = 64
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                start_i,
	input  eth_pkg::host_req_s  req_i,
	output eth_pkg::host_rsp_s  rsp_o,
	output eth_pkg::ring_wr_s   tx_wr_o,
	input  eth_pkg::ring_stat_s tx_stat_i,
	output eth_pkg::ring_rd_s   rx_rd_o,
	input  eth_pkg::ring_stat_s rx_stat_i
);
	import eth_pkg::*;

	logic        addr_ok;
	logic        commit_ok;
	logic [15:0] result_d;
	logic [15:0] result_q;
	logic        done_q;

	assign addr_ok   = (req_i.addr < host_addr_t'(SLOT_BYTES));
	assign commit_ok = !tx_stat_i.full && (tx_stat_i.wr_len != '0);

	always_comb begin
		tx_wr_o.wr_en      = start_i && (req_i.op == OP_WRITE) && addr_ok;
		tx_wr_o.addr       = req_i.addr;
		tx_wr_o.data       = req_i.wdata;
		tx_wr_o.commit     = start_i && (req_i.op == OP_WRITE_NEXT) && commit_ok;
		tx_wr_o.drop       = 1'b0; // host never abandons a packet
		rx_rd_o.addr       = req_i.addr;
		rx_rd_o.release_en = start_i && (req_i.op == OP_READ_NEXT) && !rx_stat_i.empty;
	end

	always_comb begin
		result_d = '0;
		case (req_i.op)
			OP_READ: if (req_i.addr < rx_stat_i.rd_len) begin
				result_d = {8'h00, rx_stat_i.rd_data};
			end
			OP_READ_LEN:   result_d = rx_stat_i.rd_len;
			OP_READ_NEXT:  result_d = {15'd0, rx_stat_i.empty}; // 1 means nothing to read
			OP_WRITE:      result_d = {15'd0, !addr_ok};
			OP_WRITE_LEN:  result_d = tx_stat_i.wr_len;
			OP_WRITE_NEXT: result_d = {15'd0, !commit_ok};
			default:       result_d = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done_q   <= 1'b0;
			result_q <= '0;
		end else begin
			done_q <= start_i; // one cycle after start
			if (start_i) begin
				result_q <= result_d;
			end
		end
	end

	assign rsp_o = '{done: done_q, result: result_q};

endmodule

// File: design/gmii_rx_deframer.sv
`timescale 1ns/1ps

module gmii_rx_deframer #(
	parameter int SLOT_BYTES = 64
) (
	input  logic                clock,
	input  logic                reset,
	input  eth_pkg::gmii_rx_s   gmii_i,
	output eth_pkg::ring_wr_s   wr_o,
	input  eth_pkg::ring_stat_s stat_i
);
	import eth_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_DATA,
		RX_DISCARD
	} rx_state_e;

	rx_state_e   state;
	pkt_len_t    cnt;
	logic [31:0] crc;
	logic        in_data;
	logic        byte_ok;
	logic        frame_end;
	logic        fcs_ok;

	assign in_data   = (state == RX_DATA);
	assign byte_ok   = gmii_i.rx_dv && !gmii_i.rx_er && (cnt < pkt_len_t'(SLOT_BYTES));
	assign frame_end = in_data && !gmii_i.rx_dv;
	assign fcs_ok    = (crc == CRC_RESIDUE) && !stat_i.full;

	// ------------------------------
	// ring side, straight from the wire

	always_comb begin
		wr_o.wr_en  = in_data && byte_ok;
		wr_o.addr   = cnt;
		wr_o.data   = gmii_i.rxd;
		wr_o.commit = frame_end && fcs_ok;
		wr_o.drop   = in_data && !byte_ok && !(frame_end && fcs_ok); // error, overflow or bad fcs
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RX_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				RX_IDLE: if (gmii_i.rx_dv) begin
					cnt <= 16'd1;
					if (!gmii_i.rx_er && (gmii_i.rxd == PREAMBLE_BYTE)) begin
						state <= RX_PREAMBLE;
					end else begin
						state <= RX_DISCARD;
					end
				end
				RX_PREAMBLE: begin
					if (!gmii_i.rx_dv) begin
						state <= RX_IDLE;
					end else if (gmii_i.rx_er) begin
						state <= RX_DISCARD;
					end else if ((gmii_i.rxd == PREAMBLE_BYTE) &&
							(cnt < pkt_len_t'(PREAMBLE_LEN))) begin
						cnt <= cnt + 16'd1;
					end else if ((gmii_i.rxd == SFD_BYTE) &&
							(cnt == pkt_len_t'(PREAMBLE_LEN))) begin
						cnt   <= '0;
						crc   <= CRC_INIT;
						state <= RX_DATA;
					end else begin
						state <= RX_DISCARD; // wrong preamble count
					end
				end
				RX_DATA: begin
					if (!gmii_i.rx_dv) begin
						state <= RX_IDLE;
					end else if (byte_ok) begin
						crc <= crc32_next(crc, gmii_i.rxd);
						cnt <= cnt + 16'd1;
					end else begin
						state <= RX_DISCARD;
					end
				end
				RX_DISCARD: if (!gmii_i.rx_dv) begin
					state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

// File: design/gmii_tx_framer.sv
`timescale 1ns/1ps

module gmii_tx_framer (
	input  logic                clock,
	input  logic                reset,
	output eth_pkg::ring_rd_s   rd_o,
	input  eth_pkg::ring_stat_s stat_i,
	output eth_pkg::gmii_tx_s   gmii_o
);
	import eth_pkg::*;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_DATA,
		TX_FCS,
		TX_GAP
	} tx_state_e;

	tx_state_e   state;
	pkt_len_t    cnt;       // bytes or gap cycles so far
	logic [31:0] crc;
	byte_t       txd;
	logic        tx_en;
	logic        last_fcs;

	assign last_fcs = (state == TX_FCS) && (cnt == pkt_len_t'(FCS_BYTES));

	always_comb begin
		rd_o.addr       = cnt;
		rd_o.release_en = last_fcs; // slot freed with the last fcs byte
	end

	assign gmii_o = '{txd: txd, tx_en: tx_en};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= TX_IDLE;
			cnt   <= '0;
			tx_en <= 1'b0;
			txd   <= '0;
		end else begin
			case (state)
				TX_IDLE: if (!stat_i.empty) begin
					tx_en <= 1'b1;
					txd   <= PREAMBLE_BYTE;
					cnt   <= 16'd1;
					state <= TX_PREAMBLE;
				end
				TX_PREAMBLE: if (cnt < pkt_len_t'(PREAMBLE_LEN)) begin
					txd <= PREAMBLE_BYTE;
					cnt <= cnt + 16'd1;
				end else begin
					txd   <= SFD_BYTE;
					cnt   <= '0;
					crc   <= CRC_INIT;
					state <= TX_SFD;
				end
				TX_SFD, TX_DATA: if (cnt < stat_i.rd_len) begin
					txd   <= stat_i.rd_data;
					crc   <= crc32_next(crc, stat_i.rd_data);
					cnt   <= cnt + 16'd1;
					state <= TX_DATA;
				end else begin
					txd   <= ~crc[7:0]; // fcs low byte first
					crc   <= {8'h00, crc[31:8]};
					cnt   <= 16'd1;
					state <= TX_FCS;
				end
				TX_FCS: if (last_fcs) begin
					tx_en <= 1'b0;
					txd   <= '0;
					cnt   <= 16'd1;
					state <= TX_GAP;
				end else begin
					txd <= ~crc[7:0];
					crc <= {8'h00, crc[31:8]};
					cnt <= cnt + 16'd1;
				end
				TX_GAP: if (cnt < pkt_len_t'(IFG_CYCLES)) begin
					cnt <= cnt + 16'd1;
				end else begin
					state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// File: design/packet_ring.sv
`timescale 1ns/1ps

module packet_ring #(
	parameter int NUM_SLOTS  = 4,
	parameter int SLOT_BYTES = 64,
	parameter int TRIM_BYTES = 0
) (
	input  logic                clock,
	input  logic                reset,
	input  eth_pkg::ring_wr_s   wr_i,
	input  eth_pkg::ring_rd_s   rd_i,
	output eth_pkg::ring_stat_s stat_o
);
	import eth_pkg::*;

	localparam int PTR_W  = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
	localparam int ADDR_W = (SLOT_BYTES > 1) ? $clog2(SLOT_BYTES) : 1;

	byte_t            mem [NUM_SLOTS][SLOT_BYTES];
	pkt_len_t         slot_len [NUM_SLOTS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr_nxt;
	logic [PTR_W-1:0] rd_ptr_nxt;
	pkt_len_t         wr_len;
	pkt_len_t         addr_len;
	logic             wr_hit;
	logic             rd_hit;
	logic             empty;
	logic             full;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(NUM_SLOTS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign wr_ptr_nxt = ptr_inc(wr_ptr);
	assign rd_ptr_nxt = ptr_inc(rd_ptr);
	assign empty      = (wr_ptr == rd_ptr);
	assign full       = (wr_ptr_nxt == rd_ptr); // one slot kept for assembly
	assign wr_len     = slot_len[wr_ptr];
	assign wr_hit     = wr_i.wr_en && (wr_i.addr < host_addr_t'(SLOT_BYTES));
	assign rd_hit     = (rd_i.addr < host_addr_t'(SLOT_BYTES));
	assign addr_len   = wr_i.addr + 16'd1;

	// ------------------------------
	// byte storage

	always_ff @(posedge clock) begin
		if (wr_hit) begin
			mem[wr_ptr][wr_i.addr[ADDR_W-1:0]] <= wr_i.data;
		end
	end

	// ------------------------------
	// pointers and lengths

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				slot_len[i] <= '0;
			end
		end else begin
			if (wr_hit && (addr_len > wr_len)) begin
				slot_len[wr_ptr] <= addr_len; // highest address plus one
			end
			if (wr_i.commit) begin
				if (wr_len > pkt_len_t'(TRIM_BYTES)) begin
					slot_len[wr_ptr] <= wr_len - pkt_len_t'(TRIM_BYTES);
					wr_ptr           <= wr_ptr_nxt;
				end else begin
					slot_len[wr_ptr] <= '0; // nothing left after trim
				end
			end else if (wr_i.drop) begin
				slot_len[wr_ptr] <= '0;
			end
			if (rd_i.release_en) begin
				slot_len[rd_ptr] <= '0;
				rd_ptr           <= rd_ptr_nxt;
			end
		end
	end

	always_comb begin
		stat_o.wr_len  = wr_len;
		stat_o.rd_len  = empty ? '0 : slot_len[rd_ptr]; // hide the slot in assembly
		stat_o.rd_data = rd_hit ? mem[rd_ptr][rd_i.addr[ADDR_W-1:0]] : '0;
		stat_o.empty   = empty;
		stat_o.full    = full;
	end

endmodule

// File: design/eth_pkg.sv
package eth_pkg;

	// ------------------------------
	// basic types

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] host_addr_t;
	typedef logic [15:0] pkt_len_t;

	typedef enum logic [2:0] {
		OP_READ       = 3'd0,
		OP_READ_LEN   = 3'd1,
		OP_READ_NEXT  = 3'd2,
		OP_WRITE      = 3'd3,
		OP_WRITE_LEN  = 3'd4,
		OP_WRITE_NEXT = 3'd5
	} host_op_e;

	typedef struct packed {
		host_op_e   op;
		host_addr_t addr;
		byte_t      wdata;
	} host_req_s;

	typedef struct packed {
		logic        done;
		logic [15:0] result;
	} host_rsp_s;

	typedef struct packed {
		logic       wr_en;
		host_addr_t addr;
		byte_t      data;
		logic       commit; // close the slot being assembled
		logic       drop;
	} ring_wr_s;

	typedef struct packed {
		host_addr_t addr;
		logic       release_en; // free the oldest slot
	} ring_rd_s;

	typedef struct packed {
		pkt_len_t wr_len;
		pkt_len_t rd_len;
		byte_t    rd_data;
		logic     empty;
		logic     full;
	} ring_stat_s;

	typedef struct packed {
		byte_t txd;
		logic  tx_en;
	} gmii_tx_s;

	typedef struct packed {
		byte_t rxd;
		logic  rx_dv;
		logic  rx_er;
	} gmii_rx_s;

	// ------------------------------
	// framing constants

	localparam byte_t       PREAMBLE_BYTE = 8'h55;
	localparam byte_t       SFD_BYTE      = 8'hD5;
	localparam int          PREAMBLE_LEN  = 7;
	localparam int          FCS_BYTES     = 4;
	localparam int          IFG_CYCLES    = 12;
	localparam logic [31:0] CRC_INIT      = 32'hFFFFFFFF;
	localparam logic [31:0] CRC_RESIDUE   = 32'hDEBB20E3; // register after data plus fcs

	// reflected crc-32, lsb first
	function automatic logic [31:0] crc32_next(input logic [31:0] crc, input byte_t data);
		logic [31:0] c;
		c = crc ^ {24'h000000, data};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
		end
		return c;
	endfunction

endpackage
